//--- soc_lite.f
soc_pkg.sv
bram.sv
tx_fifo.sv
uart_tx.sv
uart_rx.sv
soc_bus_decode.sv
soc_lite.sv
tb_soc_lite.sv

//--- Bender.yml
package:
  name: soc_lite

sources:
  - soc_pkg.sv
  - bram.sv
  - tx_fifo.sv
  - uart_tx.sv
  - uart_rx.sv
  - soc_bus_decode.sv
  - soc_lite.sv
  - target: test
    files:
      - tb_soc_lite.sv

//--- tb_soc_lite.sv
/*
 * Self-checking testbench for the peripheral subsystem. Acts as the bus
 * master, keeps a reference model and decodes the looped-back serial line.
 */

`timescale 1ns/1ps

module tb_soc_lite
    import soc_pkg::*;
();

    localparam logic [31:0] IDLE_ADDR    = 32'hF000_0000;
    localparam int          POLL_LIMIT   = 1000;
    localparam int          SERIAL_LIMIT = 40 * CLKS_PER_BIT;

    logic        clk = 1'b0;
    logic        reset_i;
    logic [31:0] addr;
    logic        we;
    logic [3:0]  wr_mask;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [7:0]  display;
    wire         serial_line;

    logic [31:0] lcg_state = 32'd36;
    logic [31:0] ram_model [RAM_WORDS];
    logic [7:0]  display_model;
    logic [7:0]  expected_bytes [$];
    logic [7:0]  serial_seen [$];

    always #5 clk = ~clk;

    // tx_o drives rx_i for loopback
    soc_lite i_soc_lite (
        .clk       (clk),
        .reset_i   (reset_i),
        .addr_i    (addr),
        .we_i      (we),
        .wr_mask_i (wr_mask),
        .wdata_i   (wdata),
        .rdata_o   (rdata),
        .display_o (display),
        .rx_i      (serial_line),
        .tx_o      (serial_line)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] ram_addr(input logic [RAM_AW-1:0] idx);
        return {REGION_RAM, (26 - RAM_AW)'(0), idx, 2'b00};
    endfunction

    function automatic logic [31:0] periph_addr(input logic [1:0] sel, input logic [11:0] ofs);
        return {REGION_PERIPH, 14'h0000, sel, ofs};
    endfunction

    task automatic end_in_failure(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            end_in_failure($sformatf("ERR %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // one write cycle followed by an idle bus
    task automatic bus_write(input logic [31:0] a, input logic [3:0] m, input logic [31:0] d);
        @(posedge clk);
        addr    <= a;
        we      <= 1'b1;
        wr_mask <= m;
        wdata   <= d;
        @(posedge clk);
        addr    <= IDLE_ADDR;
        we      <= 1'b0;
        wr_mask <= 4'h0;
        wdata   <= '0;
    endtask

    // data for the address comes back one cycle later
    task automatic bus_read(input logic [31:0] a, output logic [31:0] d);
        @(posedge clk);
        addr    <= a;
        we      <= 1'b0;
        wr_mask <= 4'h0;
        @(posedge clk);
        addr    <= IDLE_ADDR;
        @(negedge clk);
        d = rdata;
    endtask

    task automatic poll_status(input int bit_pos, input logic want, input string what);
        logic [31:0] status;
        int tries;
        tries = 0;
        bus_read(periph_addr(PERIPH_UART, UART_STATUS_OFS), status);
        while (status[bit_pos] !== want) begin
            tries++;
            if (tries >= POLL_LIMIT) begin
                end_in_failure($sformatf("timeout: %s never happened", what));
            end else begin
                bus_read(periph_addr(PERIPH_UART, UART_STATUS_OFS), status);
            end
        end
    endtask

    // the monitor pushes on falling edges, so look on rising edges
    task automatic next_serial_byte(output logic [7:0] b);
        int waited;
        waited = 0;
        while (serial_seen.size() == 0) begin
            if (waited >= SERIAL_LIMIT) begin
                end_in_failure("timeout: no byte appeared on the serial line");
            end else begin
                @(posedge clk);
                waited++;
            end
        end
        b = serial_seen.pop_front();
    endtask

    // serial monitor sampling each bit in its middle
    initial begin
        logic [7:0] bits;
        forever begin
            @(negedge clk);
            if (reset_i === 1'b0 && serial_line === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                check_value("serial start bit", 32'd0, serial_line);
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    bits[i] = serial_line;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                check_value("serial stop bit", 32'd1, serial_line);
                serial_seen.push_back(bits);
            end
        end
    end

    initial begin
        logic [31:0]       rd;
        logic [31:0]       rnd;
        logic [31:0]       data;
        logic [3:0]        mask;
        logic [RAM_AW-1:0] idx_list [16];
        logic [RAM_AW-1:0] idx;
        logic [7:0]        got;
        logic [7:0]        last_accepted;
        logic              pop_now;
        logic              busy_model;
        int                fifo_count;

        reset_i <= 1'b1;
        addr    <= IDLE_ADDR;
        we      <= 1'b0;
        wr_mask <= 4'h0;
        wdata   <= '0;
        display_model = 8'h00;
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;

        // state straight after reset
        @(negedge clk);
        check_value("reset tx_o", 32'd1, serial_line);
        check_value("reset display_o", 32'd0, display);
        bus_read(periph_addr(PERIPH_UART, UART_STATUS_OFS), rd);
        check_value("reset status", 32'(1) << STATUS_TX_IDLE_BIT, rd);
        bus_read(periph_addr(PERIPH_UART, 12'h008), rd);
        check_value("unmapped uart offset", 32'd0, rd);
        bus_read(periph_addr(2'd0, 12'h000), rd);
        check_value("unmapped periph select", 32'd0, rd);

        // RAM gets full words first so every tracked word is known
        for (int i = 0; i < 16; i++) begin
            rnd = next_rand();
            idx_list[i] = rnd[25:16];
            data = next_rand();
            bus_write(ram_addr(idx_list[i]), 4'hF, data);
            ram_model[idx_list[i]] = data;
        end
        for (int i = 0; i < 48; i++) begin
            rnd  = next_rand();
            idx  = idx_list[rnd[19:16]];
            mask = rnd[27:24];
            data = next_rand();
            bus_write(ram_addr(idx), mask, data);
            for (int l = 0; l < 4; l++) begin
                if (mask[l]) ram_model[idx][8*l +: 8] = data[8*l +: 8];
            end
        end
        for (int i = 0; i < 16; i++) begin
            bus_read(ram_addr(idx_list[i]), rd);
            check_value("ram readback", ram_model[idx_list[i]], rd);
        end

        // display register takes lane 0 only
        for (int i = 0; i < 8; i++) begin
            rnd  = next_rand();
            data = next_rand();
            mask = rnd[7:4];
            bus_write(periph_addr(PERIPH_DISPLAY, 12'h000), mask, data);
            if (mask[0]) display_model = data[7:0];
            @(negedge clk);
            check_value("display_o", {24'h0, display_model}, {24'h0, display});
            bus_read(periph_addr(PERIPH_DISPLAY, 12'h000), rd);
            check_value("display readback", {24'h0, display_model}, rd);
        end

        // transmit one byte at a time and receive it through the loopback
        for (int i = 0; i < 6; i++) begin
            poll_status(STATUS_TX_FULL_BIT, 1'b0, "TX_FULL clearing");
            data = next_rand();
            bus_write(periph_addr(PERIPH_UART, UART_DATA_OFS), 4'hF, data);
            expected_bytes.push_back(data[7:0]);
            next_serial_byte(got);
            check_value("uart tx byte", expected_bytes.pop_front(), got);
            poll_status(STATUS_RX_VALID_BIT, 1'b1, "RX_VALID setting");
            bus_read(periph_addr(PERIPH_UART, UART_DATA_OFS), rd);
            check_value("uart rx byte", {24'h0, data[7:0]}, rd);
            bus_read(periph_addr(PERIPH_UART, UART_STATUS_OFS), rd);
            check_value("rx valid after read", 32'd0, rd[STATUS_RX_VALID_BIT]);
        end

        // back-pressure burst with writes on consecutive cycles
        poll_status(STATUS_TX_IDLE_BIT, 1'b1, "TX_IDLE before burst");
        fifo_count = 0;
        busy_model = 1'b0;
        for (int i = 0; i < TX_FIFO_DEPTH + 3; i++) begin
            rnd = next_rand();
            @(posedge clk);
            addr    <= periph_addr(PERIPH_UART, UART_DATA_OFS);
            we      <= 1'b1;
            wr_mask <= 4'hF;
            wdata   <= rnd;
            // an idle serializer pops the head in the same cycle
            pop_now = !busy_model && (fifo_count > 0);
            if (fifo_count < TX_FIFO_DEPTH) begin
                expected_bytes.push_back(rnd[7:0]);
                last_accepted = rnd[7:0];
                fifo_count++;
            end
            if (pop_now) begin
                fifo_count--;
                busy_model = 1'b1;
            end
        end
        @(posedge clk);
        addr    <= IDLE_ADDR;
        we      <= 1'b0;
        wr_mask <= 4'h0;
        bus_read(periph_addr(PERIPH_UART, UART_STATUS_OFS), rd);
        check_value("tx full after burst", fifo_count == TX_FIFO_DEPTH, rd[STATUS_TX_FULL_BIT]);
        while (expected_bytes.size() > 0) begin
            next_serial_byte(got);
            check_value("burst tx byte", expected_bytes.pop_front(), got);
        end
        poll_status(STATUS_TX_IDLE_BIT, 1'b1, "TX_IDLE after burst");
        check_value("extra serial bytes", 32'd0, serial_seen.size());
        poll_status(STATUS_RX_VALID_BIT, 1'b1, "RX_VALID after burst");
        bus_read(periph_addr(PERIPH_UART, UART_DATA_OFS), rd);
        check_value("last burst byte received", {24'h0, last_accepted}, rd);

        $display("Test OK");
        $finish;
    end

endmodule

//--- soc_lite.sv
/*
 * Top level of the peripheral subsystem. An external bus master drives the
 * decoder, which fronts the block RAM, the display register and the UART.
 */

`timescale 1ns/1ps

module soc_lite
    import soc_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  bus_addr_t   addr_i,
    input  logic        we_i,
    input  logic [3:0]  wr_mask_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata_o,
    output logic [7:0]  display_o,
    input  logic        rx_i,
    output logic        tx_o
);

    // RAM
    logic        ram_sel;
    logic        ram_we;
    logic [31:0] ram_rdata;

    // transmit path
    logic        tx_push;
    logic [7:0]  tx_byte;
    logic        tx_pop;
    logic [7:0]  tx_head;
    logic        tx_empty;
    logic        tx_full;
    logic        tx_busy;
    logic        tx_idle;

    // receive path
    logic        rx_rd;
    logic [7:0]  rx_data;
    logic        rx_valid;

    // nothing queued and nothing on the line
    assign tx_idle = tx_empty && !tx_busy;

    soc_bus_decode i_soc_bus_decode (
        .clk         (clk),
        .reset_i     (reset_i),
        .addr_i      (addr_i),
        .we_i        (we_i),
        .wr_mask_i   (wr_mask_i),
        .wdata_i     (wdata_i),
        .ram_rdata_i (ram_rdata),
        .tx_full_i   (tx_full),
        .tx_idle_i   (tx_idle),
        .rx_data_i   (rx_data),
        .rx_valid_i  (rx_valid),
        .ram_sel_o   (ram_sel),
        .ram_we_o    (ram_we),
        .tx_push_o   (tx_push),
        .tx_byte_o   (tx_byte),
        .rx_rd_o     (rx_rd),
        .display_o   (display_o),
        .rdata_o     (rdata_o)
    );

    bram i_bram (
        .clk         (clk),
        .sel_i       (ram_sel),
        .we_i        (ram_we),
        .wr_mask_i   (wr_mask_i),
        .word_addr_i (addr_i.mem.word_idx),
        .wdata_i     (wdata_i),
        .rdata_o     (ram_rdata)
    );

    tx_fifo i_tx_fifo (
        .clk     (clk),
        .reset_i (reset_i),
        .push_i  (tx_push),
        .data_i  (tx_byte),
        .pop_i   (tx_pop),
        .data_o  (tx_head),
        .empty_o (tx_empty),
        .full_o  (tx_full)
    );

    uart_tx i_uart_tx (
        .clk     (clk),
        .reset_i (reset_i),
        .empty_i (tx_empty),
        .data_i  (tx_head),
        .pop_o   (tx_pop),
        .busy_o  (tx_busy),
        .tx_o    (tx_o)
    );

    uart_rx i_uart_rx (
        .clk     (clk),
        .reset_i (reset_i),
        .rx_i    (rx_i),
        .rd_i    (rx_rd),
        .data_o  (rx_data),
        .valid_o (rx_valid)
    );

endmodule

//--- soc_bus_decode.sv
/*
 * Address decoder for the external bus. Routes accesses to RAM, the display
 * register and the UART, and returns read data with one cycle of latency.
 */

`timescale 1ns/1ps

module soc_bus_decode
    import soc_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  bus_addr_t   addr_i,
    input  logic        we_i,
    input  logic [3:0]  wr_mask_i,
    input  logic [31:0] wdata_i,
    input  logic [31:0] ram_rdata_i,
    input  logic        tx_full_i,
    input  logic        tx_idle_i,
    input  logic [7:0]  rx_data_i,
    input  logic        rx_valid_i,
    output logic        ram_sel_o,
    output logic        ram_we_o,
    output logic        tx_push_o,
    output logic [7:0]  tx_byte_o,
    output logic        rx_rd_o,
    output logic [7:0]  display_o,
    output logic [31:0] rdata_o
);

    logic        is_periph;
    logic        is_display;
    logic        is_uart;
    logic        uart_data;
    logic        uart_status;
    logic        display_we;
    logic [31:0] periph_word;
    logic        rd_ram_q;
    logic [31:0] periph_rdata_q;

    // region decode through the memory view
    assign ram_sel_o = (addr_i.mem.region == REGION_RAM);
    assign ram_we_o  = ram_sel_o && we_i;

    // register decode through the peripheral view
    assign is_periph   = (addr_i.periph.region == REGION_PERIPH);
    assign is_display  = is_periph && (addr_i.periph.sel == PERIPH_DISPLAY);
    assign is_uart     = is_periph && (addr_i.periph.sel == PERIPH_UART);
    assign uart_data   = is_uart && (addr_i.periph.offset == UART_DATA_OFS);
    assign uart_status = is_uart && (addr_i.periph.offset == UART_STATUS_OFS);

    // byte registers only take lane 0
    assign display_we = is_display && we_i && wr_mask_i[0];
    assign tx_push_o  = uart_data && we_i && wr_mask_i[0];
    assign tx_byte_o  = wdata_i[7:0];
    assign rx_rd_o    = uart_data && !we_i;

    // peripheral read word is zero when nothing matches
    always_comb begin
        periph_word = '0;
        if (is_display) begin
            periph_word[7:0] = display_o;
        end else if (uart_data) begin
            periph_word[7:0] = rx_data_i;
        end else if (uart_status) begin
            periph_word[STATUS_TX_FULL_BIT]  = tx_full_i;
            periph_word[STATUS_RX_VALID_BIT] = rx_valid_i;
            periph_word[STATUS_TX_IDLE_BIT]  = tx_idle_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_ram_q       <= 1'b0;
            periph_rdata_q <= '0;
            display_o      <= '0;
        end else begin
            // remember the read target so RAM and registers line up
            rd_ram_q       <= ram_sel_o && !we_i;
            periph_rdata_q <= we_i ? '0 : periph_word;
            if (display_we) begin
                display_o <= wdata_i[7:0];
            end
        end
    end

    // RAM data arrives one cycle late from the block itself
    assign rdata_o = rd_ram_q ? ram_rdata_i : periph_rdata_q;

    // a full transmit FIFO never reads as idle
    a_full_not_idle: assert property (
        @(posedge clk) disable iff (reset_i)
        !(tx_full_i && tx_idle_i)
    ) else $error("tx full and tx idle reported together");

endmodule

//--- uart_rx.sv
/*
 * 8-N-1 deserializer. Samples each bit in its middle and keeps the last
 * byte with a valid flag until software reads the data register.
 */

`timescale 1ns/1ps

module uart_rx
    import soc_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    input  logic       rx_i,
    input  logic       rd_i,
    output logic [7:0] data_o,
    output logic       valid_o
);

    logic                  rx_meta;
    logic                  rx_sync;
    logic                  active_q;
    logic [3:0]            bit_cnt;
    logic [BAUD_CNT_W-1:0] baud_cnt;
    logic [7:0]            shift_q;
    logic                  sample;

    assign sample = active_q && (baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1));

    // two-flop synchronizer that idles high
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            active_q <= 1'b0;
            bit_cnt  <= '0;
            baud_cnt <= '0;
            valid_o  <= 1'b0;
        end else begin
            if (rd_i) begin
                valid_o <= 1'b0;
            end
            if (!active_q) begin
                if (!rx_sync) begin
                    // half a bit to the middle of the start bit
                    active_q <= 1'b1;
                    bit_cnt  <= '0;
                    baud_cnt <= BAUD_CNT_W'(CLKS_PER_BIT / 2);
                end
            end else if (sample) begin
                baud_cnt <= '0;
                if (bit_cnt == 4'd0 && rx_sync) begin
                    // only a glitch on the line
                    active_q <= 1'b0;
                end else if (bit_cnt == 4'd9) begin
                    active_q <= 1'b0;
                    // framing error drops the byte
                    if (rx_sync) begin
                        valid_o <= 1'b1;
                    end
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    // payload shifts in LSB first
    always_ff @(posedge clk) begin
        if (sample && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
        if (sample && bit_cnt == 4'd9 && rx_sync) begin
            data_o <= shift_q;
        end
    end

endmodule

//--- uart_tx.sv
/*
 * 8-N-1 serializer. Pops the transmit FIFO whenever it is idle and a byte
 * is waiting, then shifts start, data LSB first and stop onto tx_o.
 */

`timescale 1ns/1ps

module uart_tx
    import soc_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    input  logic       empty_i,
    input  logic [7:0] data_i,
    output logic       pop_o,
    output logic       busy_o,
    output logic       tx_o
);

    logic                  busy_q;
    logic [9:0]            frame_q;
    logic [3:0]            bit_cnt;
    logic [BAUD_CNT_W-1:0] baud_cnt;

    assign pop_o  = !busy_q && !empty_i;
    assign busy_o = busy_q;
    // line idles high
    assign tx_o   = busy_q ? frame_q[0] : 1'b1;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q   <= 1'b0;
            frame_q  <= '1;
            bit_cnt  <= '0;
            baud_cnt <= '0;
        end else if (!busy_q) begin
            if (!empty_i) begin
                // stop, data, start
                frame_q  <= {1'b1, data_i, 1'b0};
                busy_q   <= 1'b1;
                bit_cnt  <= '0;
                baud_cnt <= '0;
            end
        end else if (baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1)) begin
            baud_cnt <= '0;
            frame_q  <= {1'b1, frame_q[9:1]};
            if (bit_cnt == 4'd9) begin
                busy_q <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // the stop bit always drives the line high
    a_stop_high: assert property (
        @(posedge clk) disable iff (reset_i)
        (busy_q && bit_cnt == 4'd9) |-> tx_o
    ) else $error("stop bit not high on the line");

endmodule

//--- tx_fifo.sv
/*
 * Small synchronous byte FIFO between the bus decoder and the UART
 * serializer. Pushes while full are dropped.
 */

`timescale 1ns/1ps

module tx_fifo
    import soc_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    input  logic       push_i,
    input  logic [7:0] data_i,
    input  logic       pop_i,
    output logic [7:0] data_o,
    output logic       empty_o,
    output logic       full_o
);

    logic [7:0]            entries [TX_FIFO_DEPTH];
    logic [TX_FIFO_AW-1:0] rd_ptr;
    logic [TX_FIFO_AW-1:0] wr_ptr;
    logic [TX_FIFO_AW:0]   count;
    logic                  do_push;
    logic                  do_pop;

    assign full_o  = (count == (TX_FIFO_AW+1)'(TX_FIFO_DEPTH));
    assign empty_o = (count == '0);
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign data_o  = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap on their own since depth is a power of two
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // count stays in range and in step with the pointers
    a_count_consistent: assert property (
        @(posedge clk) disable iff (reset_i)
        count <= (TX_FIFO_AW+1)'(TX_FIFO_DEPTH)
            && (wr_ptr - rd_ptr) == count[TX_FIFO_AW-1:0]
    ) else $error("fifo count out of range or out of step with pointers");

    // the serializer must look at empty before it pops
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (reset_i)
        !(pop_i && empty_o)
    ) else $error("pop from empty fifo");

endmodule

//--- bram.sv
/*
 * Single-port block RAM with per-byte write mask. Reads are registered on
 * every edge, so data follows the address by one cycle.
 */

`timescale 1ns/1ps

module bram
    import soc_pkg::*;
(
    input  logic              clk,
    input  logic              sel_i,
    input  logic              we_i,
    input  logic [3:0]        wr_mask_i,
    input  logic [RAM_AW-1:0] word_addr_i,
    input  logic [31:0]       wdata_i,
    output logic [31:0]       rdata_o
);

    logic [31:0] mem [RAM_WORDS];

    // masked write with one lane per mask bit
    always_ff @(posedge clk) begin
        if (sel_i && we_i) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_mask_i[i]) begin
                    mem[word_addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
                end
            end
        end
    end

    // read-first so the old word comes back during a write
    always_ff @(posedge clk) begin
        rdata_o <= mem[word_addr_i];
    end

endmodule

//--- soc_pkg.sv
/*
 * Shared definitions for the peripheral subsystem: memory map, UART and FIFO
 * sizing, and the bus address word. Modules import it in their headers.
 */

package soc_pkg;

    // memory map regions in address bits 31:28
    localparam logic [3:0] REGION_RAM    = 4'h0;
    localparam logic [3:0] REGION_PERIPH = 4'h2;

    // peripheral select in address bits 13:12
    localparam logic [1:0] PERIPH_DISPLAY = 2'd1;
    localparam logic [1:0] PERIPH_UART    = 2'd2;

    // UART register offsets
    localparam logic [11:0] UART_DATA_OFS   = 12'h000;
    localparam logic [11:0] UART_STATUS_OFS = 12'h004;

    // UART status word bits
    localparam int STATUS_TX_FULL_BIT  = 0;
    localparam int STATUS_RX_VALID_BIT = 1;
    localparam int STATUS_TX_IDLE_BIT  = 2;

    // block RAM of 4 kB in 32-bit words
    localparam int RAM_WORDS = 1024;
    localparam int RAM_AW    = $clog2(RAM_WORDS);

    // transmit buffer
    localparam int TX_FIFO_DEPTH = 4;
    localparam int TX_FIFO_AW    = $clog2(TX_FIFO_DEPTH);

    // baud divider kept small so that simulation stays short
    localparam int CLKS_PER_BIT = 8;
    localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);

    // one bus address read either as a RAM word address or as a
    // peripheral register address
    typedef union packed {
        struct packed {
            logic [3:0]          region;
            logic [25-RAM_AW:0]  unused;
            logic [RAM_AW-1:0]   word_idx;
            logic [1:0]          byte_ofs;
        } mem;
        struct packed {
            logic [3:0]  region;
            logic [13:0] unused;
            logic [1:0]  sel;
            logic [11:0] offset;
        } periph;
    } bus_addr_t;

endpackage
